// File: build.f
+incdir+verif
hw/flight_pkg.sv
hw/uart_rx.sv
hw/command_decoder.sv
hw/imu_frame_capture.sv
hw/attitude_pid.sv
hw/motor_pwm.sv
hw/flight_top.sv
verif/tb_flight_top.sv

// File: hw/attitude_pid.sv
`default_nettype none

module attitude_pid #(
    parameter int PWM_PERIOD = 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_valid,
    input  flight_pkg::angle_t rate_x,
    input  flight_pkg::angle_t rate_y,
    input  flight_pkg::angle_t rate_z,
    input  flight_pkg::duty_t  base_throttle,
    input  flight_pkg::angle_t pitch_target,
    input  logic               armed,
    output logic               duty_valid,
    output flight_pkg::duty_t  duty_m1,
    output flight_pkg::duty_t  duty_m2,
    output flight_pkg::duty_t  duty_m3,
    output flight_pkg::duty_t  duty_m4
);
    import flight_pkg::*;

    // axis 0 pitch, 1 roll, 2 yaw
    angle_t rate [3];
    angle_t target [3];
    angle_t angle [3];
    angle_t err [3];
    angle_t prev_err [3];
    angle_t deriv [3];
    acc_t   integ [3];
    acc_t   integ_next [3];
    logic signed [31:0] term [3];
    logic signed [31:0] mix [4];
    logic signed [31:0] base_s;
    logic   s1_valid, s2_valid;

    function automatic logic signed [31:0] pid_term(angle_t e, acc_t i, angle_t d);
        logic signed [31:0] sum;
        sum = KP * 32'(e) + KI * 32'(i) + KD * 32'(d);
        return sum >>> GAIN_SHIFT;
    endfunction

    function automatic duty_t clamp_duty(logic signed [31:0] v);
        if (v < 0) return '0;
        if (v > PWM_PERIOD) return duty_t'(PWM_PERIOD);
        return duty_t'(v);
    endfunction

    assign rate[0]   = rate_x;
    assign rate[1]   = rate_y;
    assign rate[2]   = rate_z;
    assign target[0] = pitch_target;
    assign target[1] = '0;  // level roll
    assign target[2] = '0;  // hold heading
    assign base_s    = $signed({16'd0, base_throttle});

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            err[i]        = target[i] - angle[i];
            integ_next[i] = integ[i] + acc_t'(err[i]);
            deriv[i]      = err[i] - prev_err[i];  // 16-bit wrap
        end
    end

    // stage 1: gyro integration, keeps running when disarmed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            for (int i = 0; i < 3; i++) angle[i] <= '0;
        end else begin
            s1_valid <= frame_valid;
            if (frame_valid) begin
                for (int i = 0; i < 3; i++) angle[i] <= angle[i] + (rate[i] >>> RATE_SHIFT);
            end
        end
    end

    // stage 2: pid state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s2_valid <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                integ[i]    <= '0;
                prev_err[i] <= '0;
            end
        end else begin
            s2_valid <= s1_valid;
            if (s1_valid) begin
                for (int i = 0; i < 3; i++) begin
                    integ[i]    <= armed ? integ_next[i] : '0;
                    prev_err[i] <= armed ? err[i] : '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int i = 0; i < 3; i++) term[i] <= pid_term(err[i], integ_next[i], deriv[i]);
        end
    end

    // stage 3: motor mix
    assign mix[0] = base_s - term[0] - term[1] - term[2];
    assign mix[1] = base_s - term[0] + term[1] + term[2];
    assign mix[2] = base_s + term[0] - term[1] + term[2];
    assign mix[3] = base_s + term[0] + term[1] - term[2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_valid <= 1'b0;
            duty_m1    <= '0;
            duty_m2    <= '0;
            duty_m3    <= '0;
            duty_m4    <= '0;
        end else begin
            duty_valid <= s2_valid;
            if (s2_valid) begin
                duty_m1 <= armed ? clamp_duty(mix[0]) : '0;
                duty_m2 <= armed ? clamp_duty(mix[1]) : '0;
                duty_m3 <= armed ? clamp_duty(mix[2]) : '0;
                duty_m4 <= armed ? clamp_duty(mix[3]) : '0;
            end
        end
    end

    a_duty_range: assert property (@(posedge clk) disable iff (reset)
        duty_valid |-> (duty_m1 <= PWM_PERIOD) && (duty_m2 <= PWM_PERIOD) &&
                       (duty_m3 <= PWM_PERIOD) && (duty_m4 <= PWM_PERIOD))
        else $error("attitude_pid: duty above PWM period");

endmodule

`default_nettype wire

// File: hw/command_decoder.sv
`default_nettype none

module command_decoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx_valid,
    input  logic [7:0]          rx_byte,
    output flight_pkg::duty_t   base_throttle,
    output flight_pkg::angle_t  pitch_target,
    output logic                armed
);
    import flight_pkg::*;

    logic [7:0] action;

    // latest command wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) action <= 8'h00;
        else if (rx_valid) action <= rx_byte;
    end

    always_comb begin
        armed         = 1'b1;
        base_throttle = HOVER_THROTTLE;
        pitch_target  = '0;
        case (action)
            CMD_TAKEOFF: base_throttle = TAKEOFF_THROTTLE;
            CMD_HOVER:   base_throttle = HOVER_THROTTLE;
            CMD_FORWARD: begin
                base_throttle = HOVER_THROTTLE + TILT_COMP;  // tilt costs lift
                pitch_target  = FORWARD_PITCH;
            end
            default: begin
                // unknown byte disarms
                armed         = 1'b0;
                base_throttle = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/flight_pkg.sv
`default_nettype none

package flight_pkg;

    // common data types
    typedef logic signed [15:0] angle_t;  // angle, rate or error
    typedef logic [15:0]        duty_t;   // motor duty in clocks
    typedef logic signed [23:0] acc_t;    // integral accumulator

    // action command bytes
    localparam logic [7:0] CMD_TAKEOFF = 8'd1;
    localparam logic [7:0] CMD_HOVER   = 8'd2;
    localparam logic [7:0] CMD_FORWARD = 8'd3;

    // base throttle levels, in duty counts
    localparam duty_t TAKEOFF_THROTTLE = 16'd600;
    localparam duty_t HOVER_THROTTLE   = 16'd500;
    localparam duty_t TILT_COMP        = 16'd80;   // extra lift when tilted forward

    // pitch set point for forward flight
    localparam angle_t FORWARD_PITCH = 16'sd200;

    // one gain set for all axes
    localparam int KP = 4;
    localparam int KI = 1;
    localparam int KD = 2;

    localparam int GAIN_SHIFT = 4;  // scales the summed pid term
    localparam int RATE_SHIFT = 2;  // rate to angle step

    // gyro x, y, z as big-endian words
    localparam int IMU_FRAME_BYTES = 6;

endpackage

`default_nettype wire

// File: hw/flight_top.sv
`default_nettype none

module flight_top #(
    parameter int CLKS_PER_BIT = 434,
    parameter int PWM_PERIOD   = 1024
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    input  logic       imu_valid,
    input  logic       imu_sof,
    input  logic [7:0] imu_byte,
    output logic [3:0] pwm_out
);
    import flight_pkg::*;

    logic       rx_valid;
    logic [7:0] rx_byte;
    duty_t      base_throttle;
    angle_t     pitch_target;
    logic       armed;
    logic       frame_valid;
    angle_t     rate_x, rate_y, rate_z;
    logic       duty_valid;
    duty_t      duty_m1, duty_m2, duty_m3, duty_m4;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk(clk),
        .reset(reset),
        .rxd(rxd),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte)
    );

    command_decoder u_command_decoder (
        .clk(clk),
        .reset(reset),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .base_throttle(base_throttle),
        .pitch_target(pitch_target),
        .armed(armed)
    );

    imu_frame_capture u_imu_frame_capture (
        .clk(clk),
        .reset(reset),
        .imu_valid(imu_valid),
        .imu_sof(imu_sof),
        .imu_byte(imu_byte),
        .frame_valid(frame_valid),
        .rate_x(rate_x),
        .rate_y(rate_y),
        .rate_z(rate_z)
    );

    attitude_pid #(
        .PWM_PERIOD(PWM_PERIOD)
    ) u_attitude_pid (
        .clk(clk),
        .reset(reset),
        .frame_valid(frame_valid),
        .rate_x(rate_x),
        .rate_y(rate_y),
        .rate_z(rate_z),
        .base_throttle(base_throttle),
        .pitch_target(pitch_target),
        .armed(armed),
        .duty_valid(duty_valid),
        .duty_m1(duty_m1),
        .duty_m2(duty_m2),
        .duty_m3(duty_m3),
        .duty_m4(duty_m4)
    );

    motor_pwm #(
        .PWM_PERIOD(PWM_PERIOD)
    ) u_motor_pwm (
        .clk(clk),
        .reset(reset),
        .duty_valid(duty_valid),
        .duty_m1(duty_m1),
        .duty_m2(duty_m2),
        .duty_m3(duty_m3),
        .duty_m4(duty_m4),
        .pwm_out(pwm_out)
    );

endmodule

`default_nettype wire

// File: hw/imu_frame_capture.sv
`default_nettype none

module imu_frame_capture (
    input  logic               clk,
    input  logic               reset,
    input  logic               imu_valid,
    input  logic               imu_sof,
    input  logic [7:0]         imu_byte,
    output logic               frame_valid,
    output flight_pkg::angle_t rate_x,
    output flight_pkg::angle_t rate_y,
    output flight_pkg::angle_t rate_z
);
    import flight_pkg::*;

    localparam int LAST  = IMU_FRAME_BYTES - 1;
    localparam int CNT_W = $clog2(IMU_FRAME_BYTES);

    logic             synced;  // inside a frame
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] wr_idx;
    logic             last_byte;
    logic [7:0]       byte_buf [0:IMU_FRAME_BYTES-2];

    assign wr_idx    = imu_sof ? '0 : byte_cnt;
    assign last_byte = imu_valid && !imu_sof && synced && (byte_cnt == CNT_W'(LAST));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            synced      <= 1'b0;
            byte_cnt    <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= last_byte;
            if (imu_valid && imu_sof) begin
                synced   <= 1'b1;  // sof byte is byte 0
                byte_cnt <= CNT_W'(1);
            end else if (last_byte) begin
                synced   <= 1'b0;  // wait for the next sof
                byte_cnt <= '0;
            end else if (imu_valid && synced) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imu_valid && (imu_sof || synced) && !last_byte) byte_buf[wr_idx] <= imu_byte;
        if (last_byte) begin
            rate_x <= angle_t'({byte_buf[0], byte_buf[1]});
            rate_y <= angle_t'({byte_buf[2], byte_buf[3]});
            rate_z <= angle_t'({byte_buf[4], imu_byte});  // low byte of z is still on the bus
        end
    end

    a_frame_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_valid |=> !frame_valid)
        else $error("imu_frame_capture: frame_valid longer than one cycle");

endmodule

`default_nettype wire

// File: hw/motor_pwm.sv
`default_nettype none

module motor_pwm #(
    parameter int PWM_PERIOD = 1024
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              duty_valid,
    input  flight_pkg::duty_t duty_m1,
    input  flight_pkg::duty_t duty_m2,
    input  flight_pkg::duty_t duty_m3,
    input  flight_pkg::duty_t duty_m4,
    output logic [3:0]        pwm_out
);
    import flight_pkg::*;

    localparam int CNT_W = $clog2(PWM_PERIOD);

    logic [CNT_W-1:0] cnt;
    logic             wrap;
    duty_t            duty_in [4];
    duty_t            pending [4];
    duty_t            active [4];

    assign wrap       = (cnt == CNT_W'(PWM_PERIOD - 1));
    assign duty_in[0] = duty_m1;
    assign duty_in[1] = duty_m2;
    assign duty_in[2] = duty_m3;
    assign duty_in[3] = duty_m4;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt     <= '0;
            pwm_out <= '0;
            for (int i = 0; i < 4; i++) begin
                pending[i] <= '0;
                active[i]  <= '0;
            end
        end else begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            for (int i = 0; i < 4; i++) begin
                if (duty_valid) pending[i] <= duty_in[i];  // last update before wrap wins
                if (wrap) active[i] <= pending[i];
                pwm_out[i] <= (duty_t'(cnt) < active[i]);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int HALF_BIT = CLKS_PER_BIT / 2;
    localparam int CNT_W    = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} rx_state_t;

    rx_state_t  state;
    logic       rxd_meta, rxd_s, rxd_prev;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;
    logic       bit_done;
    logic       half_done;

    assign bit_done  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_done = (clk_cnt == CNT_W'(HALF_BIT - 1));
    assign rx_byte   = shift_reg;

    // two-flop sync, idle level is high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_prev <= rxd_s;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (rxd_prev && !rxd_s) state <= S_START;  // falling edge
                end
                S_START: begin
                    if (half_done) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? S_IDLE : S_DATA;  // glitch check mid-bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        clk_cnt  <= '0;
                        state    <= S_IDLE;
                        rx_valid <= rxd_s;  // framing error drops the byte
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_done) shift_reg <= {rxd_s, shift_reg[7:1]};
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("uart_rx: rx_valid held for more than one cycle");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the flight core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_flight_top -o sim_flight
./obj_dir/sim_flight | tee sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '>>> PASS' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: verif/flight_model.svh
`ifndef FLIGHT_MODEL_SVH
`define FLIGHT_MODEL_SVH

// flight constants, in duty counts and angle units
localparam int TAKEOFF_LEVEL = 600;
localparam int HOVER_LEVEL   = 500;
localparam int TILT_EXTRA    = 80;
localparam int FWD_PITCH     = 200;
localparam int P_GAIN        = 4;
localparam int I_GAIN        = 1;
localparam int D_GAIN        = 2;
localparam int SUM_SHIFT     = 4;
localparam int STEP_SHIFT    = 2;

// reference state, axis 0 pitch, 1 roll, 2 yaw
int angle_ref [3];
int integ_ref [3];
int prev_err_ref [3];
int base_ref;
int target_ref;
bit armed_ref;
int exp_duty [4];

// sign-extend the low bits of v
function automatic int wrap_to(input int v, input int bits);
    return (v <<< (32 - bits)) >>> (32 - bits);
endfunction

function automatic int limit_duty(input int v);
    if (v < 0) return 0;
    if (v > PWM_PERIOD) return PWM_PERIOD;
    return v;
endfunction

function automatic void decode_command(input logic [7:0] b);
    armed_ref  = 1'b1;
    target_ref = 0;
    case (b)
        8'd1: base_ref = TAKEOFF_LEVEL;
        8'd2: base_ref = HOVER_LEVEL;
        8'd3: begin
            base_ref   = HOVER_LEVEL + TILT_EXTRA;
            target_ref = FWD_PITCH;
        end
        default: begin
            armed_ref = 1'b0;  // unknown byte
            base_ref  = 0;
        end
    endcase
endfunction

// one gyro frame through integration, pid and mixing
function automatic void step_attitude(input int rx, input int ry, input int rz);
    int rate [3];
    int term [3];
    int err;
    int integ;
    int deriv;
    int tgt;
    rate[0] = rx;
    rate[1] = ry;
    rate[2] = rz;
    for (int i = 0; i < 3; i++) begin
        angle_ref[i] = wrap_to(angle_ref[i] + (rate[i] >>> STEP_SHIFT), 16);
        tgt   = (i == 0) ? target_ref : 0;
        err   = wrap_to(tgt - angle_ref[i], 16);
        integ = wrap_to(integ_ref[i] + err, 24);
        deriv = wrap_to(err - prev_err_ref[i], 16);
        term[i] = (P_GAIN * err + I_GAIN * integ + D_GAIN * deriv) >>> SUM_SHIFT;
        integ_ref[i]    = armed_ref ? integ : 0;  // held at zero while disarmed
        prev_err_ref[i] = armed_ref ? err : 0;
    end
    exp_duty[0] = limit_duty(base_ref - term[0] - term[1] - term[2]);
    exp_duty[1] = limit_duty(base_ref - term[0] + term[1] + term[2]);
    exp_duty[2] = limit_duty(base_ref + term[0] - term[1] + term[2]);
    exp_duty[3] = limit_duty(base_ref + term[0] + term[1] - term[2]);
    if (!armed_ref) begin
        for (int j = 0; j < 4; j++) exp_duty[j] = 0;
    end
endfunction

`endif

// File: verif/tb_flight_top.sv
`default_nettype none

module tb_flight_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = 16;
    localparam int PWM_PERIOD   = 1024;

    logic       clk = 1'b0;
    logic       reset;
    logic       rxd;
    logic       imu_valid;
    logic       imu_sof;
    logic [7:0] imu_byte;
    logic [3:0] pwm_out;

    int errors;
    int checks;
    int tests;
    int seed_word;
    int meas [4];

    `include "flight_model.svh"

    flight_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PWM_PERIOD(PWM_PERIOD)
    ) dut (
        .clk(clk),
        .reset(reset),
        .rxd(rxd),
        .imu_valid(imu_valid),
        .imu_sof(imu_sof),
        .imu_byte(imu_byte),
        .pwm_out(pwm_out)
    );

    always #5 clk = ~clk;

    function automatic int random_rate();
        return int'($urandom_range(800)) - 400;  // -400 .. 400
    endfunction

    // called on a falling edge, returns on one
    task automatic hold_line(input logic v);
        rxd = v;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_uart_byte(input logic [7:0] b, input bit bad_stop);
        @(negedge clk);
        hold_line(1'b0);
        for (int i = 0; i < 8; i++) hold_line(b[i]);  // lsb first
        hold_line(!bad_stop);
        hold_line(1'b1);
        hold_line(1'b1);
    endtask

    task automatic send_imu_frame(input int rx, input int ry, input int rz);
        logic [15:0] w [3];
        w[0] = rx[15:0];
        w[1] = ry[15:0];
        w[2] = rz[15:0];
        @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            imu_valid = 1'b1;
            imu_sof   = (i == 0);
            imu_byte  = (i % 2 == 0) ? w[i/2][15:8] : w[i/2][7:0];  // big endian
            @(negedge clk);
        end
        imu_valid = 1'b0;
        imu_sof   = 1'b0;
        imu_byte  = 8'h00;
    endtask

    // high cycles of each line over one period
    task automatic measure_pwm(input string name);
        logic [3:0] prev;
        int  waited;
        bit  edge_seen;
        bit  needs_edge;
        repeat (2 * PWM_PERIOD) @(negedge clk);  // new duty is active by now
        prev      = pwm_out;
        waited    = 0;
        edge_seen = 1'b0;
        while (!edge_seen && waited < 2 * PWM_PERIOD) begin
            @(negedge clk);
            edge_seen = |(pwm_out & ~prev);
            prev      = pwm_out;
            waited++;
        end
        needs_edge = 1'b0;
        for (int j = 0; j < 4; j++) begin
            if (exp_duty[j] > 0 && exp_duty[j] < PWM_PERIOD) needs_edge = 1'b1;
        end
        assert (edge_seen || !needs_edge) else begin
            $display("%s: no rising edge on pwm_out within two PWM periods", name);
            errors++;
        end
        for (int j = 0; j < 4; j++) meas[j] = 0;
        for (int k = 0; k < PWM_PERIOD; k++) begin
            for (int j = 0; j < 4; j++) meas[j] += int'(pwm_out[j]);
            @(negedge clk);
        end
    endtask

    // fixed_duty below zero means the model gives the expected duties
    task automatic run_frame(input string name, input int rx, input int ry, input int rz,
                             input int fixed_duty);
        send_imu_frame(rx, ry, rz);
        step_attitude(rx, ry, rz);
        if (fixed_duty >= 0) begin
            for (int j = 0; j < 4; j++) exp_duty[j] = fixed_duty;
        end
        measure_pwm(name);
        for (int j = 0; j < 4; j++) begin
            checks++;
            assert (meas[j] == exp_duty[j]) else begin
                $display("FAIL %s m%0d: expected %0d, actual %0d",
                         name, j + 1, exp_duty[j], meas[j]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic reset_disarmed();
        int e0;
        e0 = errors;
        repeat (2) run_frame("reset_disarmed", 0, 0, 0, 0);
        report_test("reset_disarmed", e0);
    endtask

    task automatic takeoff_zero_rates();
        int e0;
        e0 = errors;
        send_uart_byte(8'd1, 1'b0);
        decode_command(8'd1);
        repeat (2) run_frame("takeoff_zero_rates", 0, 0, 0, TAKEOFF_LEVEL);
        report_test("takeoff_zero_rates", e0);
    endtask

    task automatic hover_random_rates();
        int e0;
        e0 = errors;
        send_uart_byte(8'd2, 1'b0);
        decode_command(8'd2);
        repeat (8) run_frame("hover_random_rates", random_rate(), random_rate(),
                             random_rate(), -1);
        report_test("hover_random_rates", e0);
    endtask

    task automatic forward_flight();
        int e0;
        e0 = errors;
        // one disarmed frame clears integrals before re-arming
        send_uart_byte(8'h00, 1'b0);
        decode_command(8'h00);
        run_frame("forward_flight", random_rate(), random_rate(), random_rate(), -1);
        send_uart_byte(8'd3, 1'b0);
        decode_command(8'd3);
        repeat (5) run_frame("forward_flight", random_rate(), random_rate(),
                             random_rate(), -1);
        report_test("forward_flight", e0);
    endtask

    task automatic bad_bytes();
        int e0;
        e0 = errors;
        send_uart_byte(8'd1, 1'b1);  // framing error, model keeps forward
        repeat (2) run_frame("bad_bytes", random_rate(), random_rate(), random_rate(), -1);
        send_uart_byte(8'h5a, 1'b0);
        decode_command(8'h5a);
        repeat (2) run_frame("bad_bytes", random_rate(), random_rate(), random_rate(), 0);
        report_test("bad_bytes", e0);
    endtask

    initial begin
        reset     = 1'b1;
        rxd       = 1'b1;
        imu_valid = 1'b0;
        imu_sof   = 1'b0;
        imu_byte  = 8'h00;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        seed_word = $urandom(67803);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_disarmed();
        takeoff_zero_rates();
        hover_random_rates();
        forward_flight();
        bad_bytes();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
